// File: design/pi1_wb_defines.svh
// ========================================
// Widths and sizes shared by the pi1 to Wishbone memory subsystem
// Region bit is a byte-address bit and both regions alias inside
// ========================================
`ifndef PI1_WB_DEFINES_SVH
`define PI1_WB_DEFINES_SVH

`default_nettype none

// Data word width in bits
`define PI1_WB_DATA_BITS 32

// RAM depth in words
`define PI1_WB_RAM_WORDS 256

// Number of control registers
`define PI1_WB_REG_COUNT 4

// Byte-address bit that selects RAM (0) or registers (1)
`define PI1_WB_REGION_BIT 12

`default_nettype wire

`endif

// File: design/pi1_wb_pkg.sv
// ========================================
// Operation and region types for the pi1 memory subsystem
// ========================================
`default_nettype none

package pi1_wb_pkg;

	// pi1 operation codes as driven on pi1_op_i
	typedef enum logic [1:0] {
		PI_NOP = 2'b00,
		PI_WR  = 2'b01,
		PI_RD  = 2'b10,
		PI_RW  = 2'b11
	} pi_op_e;

	// Slave region picked by the region bit
	typedef enum logic {
		REGION_RAM  = 1'b0,
		REGION_REGS = 1'b1
	} wb_region_e;

endpackage

`default_nettype wire

// File: design/wb_ram.sv
// ========================================
// Word RAM that never stalls and acks one cycle later
// Upper address bits are ignored so the RAM repeats
// ========================================
`timescale 1ns/1ns
`include "pi1_wb_defines.svh"
`default_nettype none

module wb_ram (
	input  wire                              clk_i,
	input  wire                              rst_i,
	input  wire                              wb_cyc_i,
	input  wire                              wb_stb_i,
	input  wire                              wb_we_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      wb_addr_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      wb_data_i,
	input  wire [`PI1_WB_DATA_BITS/8-1:0]    wb_sel_i,
	output logic                             wb_stall_o,
	output logic                             wb_ack_o,
	output logic [`PI1_WB_DATA_BITS-1:0]     wb_data_o
);

	localparam int SEL_BITS = `PI1_WB_DATA_BITS / 8;
	localparam int OFF_BITS = $clog2(SEL_BITS);
	localparam int IDX_BITS = $clog2(`PI1_WB_RAM_WORDS);

	logic [`PI1_WB_DATA_BITS-1:0] mem [`PI1_WB_RAM_WORDS];
	logic [IDX_BITS-1:0]          idx;
	logic                         accept;

	assign idx        = wb_addr_i[OFF_BITS +: IDX_BITS];
	assign wb_stall_o = 1'b0;
	assign accept     = wb_cyc_i && wb_stb_i;

	always_ff @(posedge clk_i) begin
		if (accept && wb_we_i) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (wb_sel_i[b])
					mem[idx][8*b +: 8] <= wb_data_i[8*b +: 8];
			end
		end
		if (accept && !wb_we_i)
			wb_data_o <= mem[idx];
	end

	// Ack drops with cyc
	always_ff @(posedge clk_i) begin
		if (rst_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= accept;
	end

endmodule

`default_nettype wire

// File: design/wb_regs.sv
// ========================================
// Control registers that stall every new request once
// Registers reset to zero and alias above the register count
// ========================================
`timescale 1ns/1ns
`include "pi1_wb_defines.svh"
`default_nettype none

module wb_regs (
	input  wire                              clk_i,
	input  wire                              rst_i,
	input  wire                              wb_cyc_i,
	input  wire                              wb_stb_i,
	input  wire                              wb_we_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      wb_addr_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      wb_data_i,
	input  wire [`PI1_WB_DATA_BITS/8-1:0]    wb_sel_i,
	output logic                             wb_stall_o,
	output logic                             wb_ack_o,
	output logic [`PI1_WB_DATA_BITS-1:0]     wb_data_o
);

	localparam int SEL_BITS = `PI1_WB_DATA_BITS / 8;
	localparam int OFF_BITS = $clog2(SEL_BITS);
	localparam int IDX_BITS = $clog2(`PI1_WB_REG_COUNT);

	logic [`PI1_WB_DATA_BITS-1:0] regs [`PI1_WB_REG_COUNT];
	logic [IDX_BITS-1:0]          idx;
	logic                         wait_done;
	logic                         accept;

	assign idx = wb_addr_i[OFF_BITS +: IDX_BITS];

	// First cycle of each strobe is a wait state
	assign wb_stall_o = wb_stb_i && !wait_done;
	assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wait_done <= 1'b0;
			wb_ack_o  <= 1'b0;
		end else begin
			wait_done <= wb_cyc_i && wb_stb_i && !wait_done;
			wb_ack_o  <= accept;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int r = 0; r < `PI1_WB_REG_COUNT; r++)
				regs[r] <= '0;
		end else if (accept && wb_we_i) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (wb_sel_i[b])
					regs[idx][8*b +: 8] <= wb_data_i[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept && !wb_we_i)
			wb_data_o <= regs[idx];
	end

	a_ack_not_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		!(wb_ack_o && wb_stall_o))
		else $error("%0t: register ack raised during a stall", $time);

endmodule

`default_nettype wire

// File: design/wb_decoder.sv
// ========================================
// Combinational router between the bridge and two slaves
// ========================================
`timescale 1ns/1ns
`include "pi1_wb_defines.svh"
`default_nettype none

module wb_decoder (
	input  wire                              wb_stb_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      wb_addr_i,
	output logic                             wb_stall_o,
	output logic                             wb_ack_o,
	output logic [`PI1_WB_DATA_BITS-1:0]     wb_data_o,
	output logic                             ram_stb_o,
	input  wire                              ram_stall_i,
	input  wire                              ram_ack_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      ram_data_i,
	output logic                             regs_stb_o,
	input  wire                              regs_stall_i,
	input  wire                              regs_ack_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      regs_data_i
);

	pi1_wb_pkg::wb_region_e region;

	always_comb begin
		if (wb_addr_i[`PI1_WB_REGION_BIT])
			region = pi1_wb_pkg::REGION_REGS;
		else
			region = pi1_wb_pkg::REGION_RAM;
	end

	// Strobe goes to the addressed slave only
	assign ram_stb_o  = wb_stb_i && (region == pi1_wb_pkg::REGION_RAM);
	assign regs_stb_o = wb_stb_i && (region == pi1_wb_pkg::REGION_REGS);

	assign wb_stall_o = (region == pi1_wb_pkg::REGION_REGS) ? regs_stall_i : ram_stall_i;

	// Ack and data come from whichever slave answers
	assign wb_ack_o  = ram_ack_i || regs_ack_i;
	assign wb_data_o = regs_ack_i ? regs_data_i : ram_data_i;

	always_comb begin
		a_one_ack: assert (!(ram_ack_i === 1'b1 && regs_ack_i === 1'b1))
			else $error("%0t: RAM and register acks high together", $time);
	end

endmodule

`default_nettype wire

// File: design/pi1_to_wb.sv
// ========================================
// One pi1 operation outstanding at a time
// RW reads first and writes back after the read ack
// ========================================
`timescale 1ns/1ns
`include "pi1_wb_defines.svh"
`default_nettype none

module pi1_to_wb (
	input  wire                              clk_i,
	input  wire                              rst_i,
	input  wire pi1_wb_pkg::pi_op_e          pi1_op_i,
	input  wire [`PI1_WB_DATA_BITS-3:0]      pi1_addr_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      pi1_data_i,
	input  wire [`PI1_WB_DATA_BITS/8-1:0]    pi1_sel_i,
	output logic [`PI1_WB_DATA_BITS-1:0]     pi1_data_o,
	output logic                             pi1_rdy_o,
	output logic                             wb_cyc_o,
	output logic                             wb_stb_o,
	output logic                             wb_we_o,
	output logic [`PI1_WB_DATA_BITS-1:0]     wb_addr_o,
	output logic [`PI1_WB_DATA_BITS-1:0]     wb_data_o,
	output logic [`PI1_WB_DATA_BITS/8-1:0]   wb_sel_o,
	input  wire                              wb_stall_i,
	input  wire                              wb_ack_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      wb_data_i
);

	localparam int SEL_BITS = `PI1_WB_DATA_BITS / 8;
	localparam int OFF_BITS = $clog2(SEL_BITS);

	logic                           rw_pending;
	pi1_wb_pkg::pi_op_e             op_hold;
	logic [`PI1_WB_DATA_BITS-1:0]   rd_hold;
	logic [OFF_BITS-1:0]            byte_off;
	logic [`PI1_WB_DATA_BITS-1:0]   byte_addr;

	// Lowest selected lane gives the byte offset
	always_comb begin
		byte_off = '0;
		for (int i = SEL_BITS - 1; i >= 0; i--) begin
			if (pi1_sel_i[i])
				byte_off = OFF_BITS'(i);
		end
	end

	assign byte_addr = {pi1_addr_i, byte_off};

	// Ready when idle or when the final ack of the operation arrives
	assign pi1_rdy_o = !wb_cyc_o || (wb_ack_i && !rw_pending);

	// Swap returns the word captured at the read-phase ack
	assign pi1_data_o = (op_hold == pi1_wb_pkg::PI_RW) ? rd_hold : wb_data_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_cyc_o   <= 1'b0;
			wb_stb_o   <= 1'b0;
			rw_pending <= 1'b0;
		end else if (pi1_rdy_o) begin
			op_hold   <= pi1_op_i;
			wb_addr_o <= byte_addr;
			wb_data_o <= pi1_data_i;
			wb_sel_o  <= pi1_sel_i;
			case (pi1_op_i)
				pi1_wb_pkg::PI_RD: begin
					wb_cyc_o <= 1'b1;
					wb_stb_o <= 1'b1;
					wb_we_o  <= 1'b0;
				end
				pi1_wb_pkg::PI_WR: begin
					wb_cyc_o <= 1'b1;
					wb_stb_o <= 1'b1;
					wb_we_o  <= 1'b1;
				end
				pi1_wb_pkg::PI_RW: begin
					wb_cyc_o   <= 1'b1;
					wb_stb_o   <= 1'b1;
					wb_we_o    <= 1'b0;
					rw_pending <= 1'b1;
				end
				default: begin
					wb_cyc_o <= 1'b0;
					wb_stb_o <= 1'b0;
					wb_we_o  <= 1'b0;
				end
			endcase
		end else if (rw_pending && wb_ack_i) begin
			// Read phase done so issue the write-back
			rd_hold    <= wb_data_i;
			wb_stb_o   <= 1'b1;
			wb_we_o    <= 1'b1;
			rw_pending <= 1'b0;
		end else if (!wb_stall_i) begin
			wb_stb_o <= 1'b0;
		end
	end

	a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_stb_o |-> wb_cyc_o)
		else $error("%0t: wb_stb_o high without wb_cyc_o", $time);

	// Slaves must not ack outside a cycle
	a_no_stray_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		!wb_cyc_o |-> !wb_ack_i)
		else $error("%0t: wb_ack_i seen while wb_cyc_o is low", $time);

endmodule

`default_nettype wire

// File: design/pi1_wb_top.sv
// ========================================
// pi1 port in front of a RAM and a register bank
// ========================================
`timescale 1ns/1ns
`include "pi1_wb_defines.svh"
`default_nettype none

module pi1_wb_top (
	input  wire                              clk_i,
	input  wire                              rst_i,
	input  wire pi1_wb_pkg::pi_op_e          pi1_op_i,
	input  wire [`PI1_WB_DATA_BITS-3:0]      pi1_addr_i,
	input  wire [`PI1_WB_DATA_BITS-1:0]      pi1_data_i,
	input  wire [`PI1_WB_DATA_BITS/8-1:0]    pi1_sel_i,
	output wire [`PI1_WB_DATA_BITS-1:0]      pi1_data_o,
	output wire                              pi1_rdy_o
);

	wire                             wb_cyc;
	wire                             wb_stb;
	wire                             wb_we;
	wire [`PI1_WB_DATA_BITS-1:0]     wb_addr;
	wire [`PI1_WB_DATA_BITS-1:0]     wb_wdata;
	wire [`PI1_WB_DATA_BITS/8-1:0]   wb_sel;
	wire                             wb_stall;
	wire                             wb_ack;
	wire [`PI1_WB_DATA_BITS-1:0]     wb_rdata;

	wire                             ram_stb;
	wire                             ram_stall;
	wire                             ram_ack;
	wire [`PI1_WB_DATA_BITS-1:0]     ram_rdata;
	wire                             regs_stb;
	wire                             regs_stall;
	wire                             regs_ack;
	wire [`PI1_WB_DATA_BITS-1:0]     regs_rdata;

	pi1_to_wb bridge_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.wb_cyc_o   (wb_cyc),
		.wb_stb_o   (wb_stb),
		.wb_we_o    (wb_we),
		.wb_addr_o  (wb_addr),
		.wb_data_o  (wb_wdata),
		.wb_sel_o   (wb_sel),
		.wb_stall_i (wb_stall),
		.wb_ack_i   (wb_ack),
		.wb_data_i  (wb_rdata)
	);

	wb_decoder decoder_i (
		.wb_stb_i     (wb_stb),
		.wb_addr_i    (wb_addr),
		.wb_stall_o   (wb_stall),
		.wb_ack_o     (wb_ack),
		.wb_data_o    (wb_rdata),
		.ram_stb_o    (ram_stb),
		.ram_stall_i  (ram_stall),
		.ram_ack_i    (ram_ack),
		.ram_data_i   (ram_rdata),
		.regs_stb_o   (regs_stb),
		.regs_stall_i (regs_stall),
		.regs_ack_i   (regs_ack),
		.regs_data_i  (regs_rdata)
	);

	wb_ram ram_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (ram_stb),
		.wb_we_i    (wb_we),
		.wb_addr_i  (wb_addr),
		.wb_data_i  (wb_wdata),
		.wb_sel_i   (wb_sel),
		.wb_stall_o (ram_stall),
		.wb_ack_o   (ram_ack),
		.wb_data_o  (ram_rdata)
	);

	wb_regs regs_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (regs_stb),
		.wb_we_i    (wb_we),
		.wb_addr_i  (wb_addr),
		.wb_data_i  (wb_wdata),
		.wb_sel_i   (wb_sel),
		.wb_stall_o (regs_stall),
		.wb_ack_o   (regs_ack),
		.wb_data_o  (regs_rdata)
	);

endmodule

`default_nettype wire

// File: test/tb_pi1_wb_top.sv
// ========================================
// RAM checks use the first 16 words only, each written in full before random traffic
// Operations are issued one at a time with an idle cycle between them
// ========================================
`timescale 1ns/1ns
`include "pi1_wb_defines.svh"
`default_nettype none

module tb_pi1_wb_top;

	localparam int W          = `PI1_WB_DATA_BITS;
	localparam int LANES      = W / 8;
	localparam int REG_WBIT   = `PI1_WB_REGION_BIT - 2;
	localparam int RAM_IBITS  = $clog2(`PI1_WB_RAM_WORDS);
	localparam int REG_IBITS  = $clog2(`PI1_WB_REG_COUNT);
	localparam int RAM_SET    = 16;
	localparam int WAIT_LIMIT = 20;

	logic                 clk_i;
	logic                 rst_i;
	pi1_wb_pkg::pi_op_e   pi1_op;
	logic [W-3:0]         pi1_addr;
	logic [W-1:0]         pi1_wdata;
	logic [LANES-1:0]     pi1_sel;
	wire  [W-1:0]         pi1_rdata;
	wire                  pi1_rdy;

	// Byte model of both regions, indexed by the aliased word index
	logic [7:0]   ram_model [`PI1_WB_RAM_WORDS][LANES];
	logic [7:0]   reg_model [`PI1_WB_REG_COUNT][LANES];
	logic         pending;
	int           pend_cycles;
	int           exp_lat;
	logic         exp_rd;
	logic [W-1:0] exp_word;
	integer       seed;

	pi1_wb_top dut_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pi1_op_i   (pi1_op),
		.pi1_addr_i (pi1_addr),
		.pi1_data_i (pi1_wdata),
		.pi1_sel_i  (pi1_sel),
		.pi1_data_o (pi1_rdata),
		.pi1_rdy_o  (pi1_rdy)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	function automatic logic [W-1:0] model_word(input logic [W-3:0] waddr);
		logic [W-1:0] w;
		for (int b = 0; b < LANES; b++) begin
			if (waddr[REG_WBIT])
				w[8*b +: 8] = reg_model[waddr[REG_IBITS-1:0]][b];
			else
				w[8*b +: 8] = ram_model[waddr[RAM_IBITS-1:0]][b];
		end
		return w;
	endfunction

	task automatic model_write(input logic [W-3:0] waddr, input logic [W-1:0] data,
			input logic [LANES-1:0] sel);
		for (int b = 0; b < LANES; b++) begin
			if (sel[b] && waddr[REG_WBIT])
				reg_model[waddr[REG_IBITS-1:0]][b] = data[8*b +: 8];
			else if (sel[b])
				ram_model[waddr[RAM_IBITS-1:0]][b] = data[8*b +: 8];
		end
	endtask

	// Registers add one wait state per strobe and a swap has two strobes
	function automatic int expected_latency(input pi1_wb_pkg::pi_op_e op,
			input pi1_wb_pkg::wb_region_e region);
		int lat;
		lat = (op == pi1_wb_pkg::PI_RW) ? 4 : 2;
		if (region == pi1_wb_pkg::REGION_REGS)
			lat = (op == pi1_wb_pkg::PI_RW) ? 6 : 3;
		return lat;
	endfunction

	// Random upper bits exercise the alias rule
	function automatic logic [W-3:0] pick_addr(input pi1_wb_pkg::wb_region_e region,
			input int idx);
		logic [W-3:0] a;
		a = (W-2)'($random(seed));
		a[REG_WBIT] = (region == pi1_wb_pkg::REGION_REGS);
		if (region == pi1_wb_pkg::REGION_REGS)
			a[REG_IBITS-1:0] = idx[REG_IBITS-1:0];
		else
			a[RAM_IBITS-1:0] = idx[RAM_IBITS-1:0];
		return a;
	endfunction

	task automatic run_op(input pi1_wb_pkg::pi_op_e op, input logic [W-3:0] waddr,
			input logic [W-1:0] data, input logic [LANES-1:0] sel);
		int   cycles;
		logic done;
		@(posedge clk_i);
		pi1_op    <= op;
		pi1_addr  <= waddr;
		pi1_wdata <= data;
		pi1_sel   <= sel;
		@(negedge clk_i);
		exp_rd   = (op == pi1_wb_pkg::PI_RD) || (op == pi1_wb_pkg::PI_RW);
		exp_word = model_word(waddr);
		exp_lat  = expected_latency(op, pi1_wb_pkg::wb_region_e'(waddr[REG_WBIT]));
		// Operation is taken at this edge
		@(posedge clk_i);
		pi1_op <= pi1_wb_pkg::PI_NOP;
		if (op != pi1_wb_pkg::PI_NOP) begin
			cycles = 0;
			done   = 1'b0;
			while (!done) begin
				@(negedge clk_i);
				cycles++;
				pend_cycles = cycles;
				pending     = 1'b1;
				if (pi1_rdy)
					done = 1'b1;
				else if (cycles >= WAIT_LIMIT)
					abort_run("timeout while waiting for pi1_rdy_o after an operation");
			end
			@(negedge clk_i);
			pending = 1'b0;
			if (op != pi1_wb_pkg::PI_RD)
				model_write(waddr, data, sel);
		end
	endtask

	a_idle_ready: assert property (@(posedge clk_i) disable iff (rst_i)
		!pending |-> pi1_rdy)
		else abort_run($sformatf("error at %0t ns: pi1_rdy_o low while idle", $time));

	a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		(pending && pi1_rdy) |-> (pend_cycles == exp_lat))
		else abort_run($sformatf("error at %0t ns: ready after %0d cycles, expected %0d",
			$time, pend_cycles, exp_lat));

	a_read_data: assert property (@(posedge clk_i) disable iff (rst_i)
		(pending && pi1_rdy && exp_rd) |-> (pi1_rdata == exp_word))
		else abort_run($sformatf("error at %0t ns: read data %h, expected %h",
			$time, $sampled(pi1_rdata), exp_word));

	initial begin
		logic [31:0]              r;
		logic [W-3:0]             a;
		pi1_wb_pkg::wb_region_e   region;
		int                       idx;
		seed      = 32'hb6a1;
		rst_i     = 1'b1;
		pi1_op    = pi1_wb_pkg::PI_NOP;
		pi1_addr  = '0;
		pi1_wdata = '0;
		pi1_sel   = '0;
		pending   = 1'b0;
		exp_rd    = 1'b0;
		exp_word  = '0;
		exp_lat   = 0;
		for (int i = 0; i < `PI1_WB_REG_COUNT; i++) begin
			for (int b = 0; b < LANES; b++)
				reg_model[i][b] = 8'h00;
		end
		repeat (16) @(posedge clk_i);
		rst_i <= 1'b0;

		for (int i = 0; i < `PI1_WB_REG_COUNT; i++)
			run_op(pi1_wb_pkg::PI_RD, pick_addr(pi1_wb_pkg::REGION_REGS, i), '0, '1);
		for (int i = 0; i < RAM_SET; i++)
			run_op(pi1_wb_pkg::PI_WR, pick_addr(pi1_wb_pkg::REGION_RAM, i), $random(seed), '1);

		// Same offset in both regions must stay apart
		a = pick_addr(pi1_wb_pkg::REGION_RAM, 2);
		a[REG_WBIT] = 1'b1;
		run_op(pi1_wb_pkg::PI_WR, a, $random(seed), '1);
		run_op(pi1_wb_pkg::PI_RD, a, '0, '1);
		a[REG_WBIT] = 1'b0;
		run_op(pi1_wb_pkg::PI_RD, a, '0, '1);

		run_op(pi1_wb_pkg::PI_RW, pick_addr(pi1_wb_pkg::REGION_RAM, 5), $random(seed), 4'b0110);
		run_op(pi1_wb_pkg::PI_RD, pick_addr(pi1_wb_pkg::REGION_RAM, 5), '0, '1);
		run_op(pi1_wb_pkg::PI_RW, pick_addr(pi1_wb_pkg::REGION_REGS, 1), $random(seed), 4'b1001);
		run_op(pi1_wb_pkg::PI_RD, pick_addr(pi1_wb_pkg::REGION_REGS, 1), '0, '1);
		repeat (3)
			run_op(pi1_wb_pkg::PI_NOP, pick_addr(pi1_wb_pkg::REGION_RAM, 5), $random(seed), '1);
		run_op(pi1_wb_pkg::PI_RD, pick_addr(pi1_wb_pkg::REGION_RAM, 5), '0, '1);

		for (int n = 0; n < 300; n++) begin
			r      = $random(seed);
			region = pi1_wb_pkg::wb_region_e'(r[2]);
			if (region == pi1_wb_pkg::REGION_REGS)
				idx = int'(r[15:8]) % `PI1_WB_REG_COUNT;
			else
				idx = int'(r[15:8]) % RAM_SET;
			run_op(pi1_wb_pkg::pi_op_e'(r[1:0]), pick_addr(region, idx), $random(seed),
				r[16 +: LANES]);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: pi1_wb.f
+incdir+design
design/pi1_wb_pkg.sv
design/wb_ram.sv
design/wb_regs.sv
design/wb_decoder.sv
design/pi1_to_wb.sv
design/pi1_wb_top.sv
test/tb_pi1_wb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_pi1_wb_top -f pi1_wb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
	echo "simulation ended without a pass report"
	exit 1
fi
exit 0
